//--- common/serialize_defs.svh
////////////////////
// Compile-time sizes of the read ID serializer
// MAX_UNIQ_IDS must not exceed 2**MST_ID_W
////////////////////
`ifndef SERIALIZE_DEFS_SVH
`define SERIALIZE_DEFS_SVH

// Slave port ID width
`define SLV_ID_W 4

// Master port ID width
`define MST_ID_W 2

// Number of master IDs, one serializer slot each
`define MAX_UNIQ_IDS 4

// Reads in flight per slot before AR stalls
`define MAX_TXNS_PER_ID 4

// Added to the slave ID before the modulo
`define ID_BASE_OFFSET 1

// Address and data widths, same on both ports
`define ADDR_W 32
`define DATA_W 32

// AXI burst length field
`define LEN_W 8

`endif

//--- common/serialize_pkg.sv
////////////////////
// Types shared by the read ID serializer
// Slot mapping is static, no lookup table
////////////////////
`include "serialize_defs.svh"

package read_id_serialize_pkg;

  // Slot index width, at least one bit
  localparam int unsigned SlotW = (`MAX_UNIQ_IDS > 1) ? $clog2(`MAX_UNIQ_IDS) : 1;

  typedef logic [`SLV_ID_W-1:0] slv_id_t;
  typedef logic [`MST_ID_W-1:0] mst_id_t;
  typedef logic [SlotW-1:0]     slot_t;
  typedef logic [`ADDR_W-1:0]   addr_t;
  typedef logic [`DATA_W-1:0]   data_t;
  typedef logic [`LEN_W-1:0]    len_t;

  // AR beat as seen on the master port
  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } mst_ar_t;

  // Static slave ID to slot mapping
  // Offset first, then wrap into the slot range
  function automatic slot_t slot_of(input slv_id_t id);
    int unsigned sum;
    sum = int'(id) + `ID_BASE_OFFSET;
    return slot_t'(sum % `MAX_UNIQ_IDS);
  endfunction

endpackage

//--- id_serializer/id_serializer.sv
////////////////////
// Per-slot queue of slave IDs in flight
// R beats must return in AR order for the slot
////////////////////
`timescale 1ns/1ps
`include "serialize_defs.svh"

module id_serializer
  import read_id_serialize_pkg::*;
(
  input  logic    clk_i,
  input  logic    arst_n_i,
  // AR from the steering stage
  input  logic    ar_valid_i,
  input  slv_id_t ar_id_i,
  output logic    ar_ready_o,
  // AR toward the spill register
  output logic    ar_out_valid_o,
  input  logic    ar_out_ready_i,
  // R beats routed to this slot
  input  logic    r_valid_i,
  input  logic    r_ready_i,
  input  logic    r_last_i,
  output logic    r_valid_o,
  output slv_id_t r_id_o
);

  localparam int unsigned Depth = `MAX_TXNS_PER_ID;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  // Slave IDs of reads in flight, oldest at rd_ptr_q
  slv_id_t id_q [Depth];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;

  logic full;
  logic empty;
  logic push;
  logic pop;

  assign full  = (count_q == CntW'(Depth));
  assign empty = (count_q == '0);

  // Accept only with room left and the spill register free
  assign ar_ready_o     = ~full & ar_out_ready_i;
  assign ar_out_valid_o = ar_valid_i & ~full;

  // Push at the slave AR handshake
  assign push = ar_valid_i & ar_ready_o;

  // R only passes while a read is owed to this slot
  assign r_valid_o = r_valid_i & ~empty;
  assign r_id_o    = id_q[rd_ptr_q];

  // Entry retires on the last beat handshake
  assign pop = r_valid_o & r_ready_i & r_last_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_q[wr_ptr_q] <= ar_id_i;
    end
  end

  // Pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        if (wr_ptr_q == PtrW'(Depth - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr_q == PtrW'(Depth - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
    end
  end

  // Push and pop in the same cycle leave the count unchanged
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (push && !pop) begin
      count_q <= count_q + 1'b1;
    end else if (pop && !push) begin
      count_q <= count_q - 1'b1;
    end
  end

endmodule

//--- read_id_serialize.f
+incdir+common
common/serialize_pkg.sv
rtl/ar_steer.sv
id_serializer/id_serializer.sv
rtl/r_route.sv
rtl/spill_register.sv
rtl/read_id_serialize.sv
test/read_id_serialize_checker.sv
test/tb_read_id_serialize.sv

//--- rtl/ar_steer.sv
////////////////////
// Slave AR to slot demux, slot to master AR merge
// Purely combinational
////////////////////
`timescale 1ns/1ps
`include "serialize_defs.svh"

module ar_steer
  import read_id_serialize_pkg::*;
(
  input  logic                     slv_ar_valid_i,
  input  slv_id_t                  slv_ar_id_i,
  input  addr_t                    slv_ar_addr_i,
  input  len_t                     slv_ar_len_i,
  input  logic [`MAX_UNIQ_IDS-1:0] slot_ready_i,
  input  logic                     spill_ready_i,
  output logic                     slv_ar_ready_o,
  output logic [`MAX_UNIQ_IDS-1:0] slot_valid_o,
  output slv_id_t                  slot_id_o,
  output logic                     ar_valid_o,
  output mst_ar_t                  ar_o
);

  // Slot picked by the incoming slave ID
  slot_t sel;

  // Slots that take the beat this cycle
  logic [`MAX_UNIQ_IDS-1:0] slot_take;

  assign sel = slot_of(slv_ar_id_i);

  // Only the mapped slot sees valid
  always_comb begin
    slot_valid_o = '0;
    for (int i = 0; i < `MAX_UNIQ_IDS; i++) begin
      if (sel == slot_t'(i)) begin
        slot_valid_o[i] = slv_ar_valid_i;
      end
    end
  end

  // Every slot sees the original ID, the valid picks the owner
  assign slot_id_o = slv_ar_id_i;

  // Ready comes from the owning slot only
  assign slv_ar_ready_o = slot_ready_i[sel];

  // A slot takes the beat when its valid meets its ready
  assign slot_take = slot_valid_o & slot_ready_i;

  // Merged valid toward the spill register
  // Beat moves only on a cycle the spill register takes it
  assign ar_valid_o = spill_ready_i & (|slot_take);

  // Master ID is the slot index
  // addr and len go through untouched
  always_comb begin
    ar_o      = '0;
    ar_o.id   = mst_id_t'(sel);
    ar_o.addr = slv_ar_addr_i;
    ar_o.len  = slv_ar_len_i;
  end

endmodule

//--- rtl/r_route.sv
////////////////////
// Master R demux by ID, slot merge toward slave
// Zero-cycle path, IDs beyond the slot range get no valid
////////////////////
`timescale 1ns/1ps
`include "serialize_defs.svh"

module r_route
  import read_id_serialize_pkg::*;
(
  input  logic                                mst_r_valid_i,
  input  mst_id_t                             mst_r_id_i,
  input  data_t                               mst_r_data_i,
  input  logic                                mst_r_last_i,
  output logic                                mst_r_ready_o,
  output logic    [`MAX_UNIQ_IDS-1:0]         slot_r_valid_o,
  input  logic    [`MAX_UNIQ_IDS-1:0]         slot_r_valid_i,
  input  slv_id_t [`MAX_UNIQ_IDS-1:0]         slot_r_id_i,
  output logic                                slv_r_valid_o,
  input  logic                                slv_r_ready_i,
  output slv_id_t                             slv_r_id_o,
  output data_t                               slv_r_data_o,
  output logic                                slv_r_last_o
);

  // Index of the slot holding the beat
  slot_t act;

  // Master ID names the slot directly
  always_comb begin
    slot_r_valid_o = '0;
    for (int i = 0; i < `MAX_UNIQ_IDS; i++) begin
      if (mst_r_id_i == mst_id_t'(i)) begin
        slot_r_valid_o[i] = mst_r_valid_i;
      end
    end
  end

  // One-hot slot valid back to an index
  always_comb begin
    act = '0;
    for (int i = 0; i < `MAX_UNIQ_IDS; i++) begin
      if (slot_r_valid_i[i]) begin
        act = slot_t'(i);
      end
    end
  end

  // At most one slot is active
  assign slv_r_valid_o = |slot_r_valid_i;
  assign slv_r_id_o    = slot_r_id_i[act];
  assign slv_r_data_o  = mst_r_data_i;
  assign slv_r_last_o  = mst_r_last_i;

  // Stall the master while no slot owns the beat
  assign mst_r_ready_o = slv_r_ready_i & (|slot_r_valid_i);

endmodule

//--- rtl/read_id_serialize.sv
////////////////////
// Read-only AXI ID serializer, write channels not handled
// Slot is (ID + offset) mod MAX_UNIQ_IDS
////////////////////
`timescale 1ns/1ps
`include "serialize_defs.svh"

module read_id_serialize
  import read_id_serialize_pkg::*;
(
  input  logic    clk_i,
  input  logic    arst_n_i,
  // Slave AR
  input  logic    slv_ar_valid_i,
  output logic    slv_ar_ready_o,
  input  slv_id_t slv_ar_id_i,
  input  addr_t   slv_ar_addr_i,
  input  len_t    slv_ar_len_i,
  // Slave R
  output logic    slv_r_valid_o,
  input  logic    slv_r_ready_i,
  output slv_id_t slv_r_id_o,
  output data_t   slv_r_data_o,
  output logic    slv_r_last_o,
  // Master AR
  output logic    mst_ar_valid_o,
  input  logic    mst_ar_ready_i,
  output mst_id_t mst_ar_id_o,
  output addr_t   mst_ar_addr_o,
  output len_t    mst_ar_len_o,
  // Master R
  input  logic    mst_r_valid_i,
  output logic    mst_r_ready_o,
  input  mst_id_t mst_r_id_i,
  input  data_t   mst_r_data_i,
  input  logic    mst_r_last_i
);

  logic    [`MAX_UNIQ_IDS-1:0] slot_ar_valid;
  logic    [`MAX_UNIQ_IDS-1:0] slot_ar_ready;
  slv_id_t                     slot_ar_id;
  logic                        spill_ready;
  logic                        merged_ar_valid;
  mst_ar_t                     merged_ar;
  mst_ar_t                     mst_ar;
  logic    [`MAX_UNIQ_IDS-1:0] route_r_valid;
  logic    [`MAX_UNIQ_IDS-1:0] slot_r_valid;
  slv_id_t [`MAX_UNIQ_IDS-1:0] slot_r_id;

  ar_steer i_ar_steer (
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_id_i    (slv_ar_id_i),
    .slv_ar_addr_i  (slv_ar_addr_i),
    .slv_ar_len_i   (slv_ar_len_i),
    .slot_ready_i   (slot_ar_ready),
    .spill_ready_i  (spill_ready),
    .slv_ar_ready_o (slv_ar_ready_o),
    .slot_valid_o   (slot_ar_valid),
    .slot_id_o      (slot_ar_id),
    .ar_valid_o     (merged_ar_valid),
    .ar_o           (merged_ar)
  );

  // One serializer per master ID
  for (genvar i = 0; i < `MAX_UNIQ_IDS; i++) begin : gen_slot
    id_serializer i_id_serializer (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .ar_valid_i     (slot_ar_valid[i]),
      .ar_id_i        (slot_ar_id),
      .ar_ready_o     (slot_ar_ready[i]),
      .ar_out_valid_o (),
      .ar_out_ready_i (spill_ready),
      .r_valid_i      (route_r_valid[i]),
      .r_ready_i      (slv_r_ready_i),
      .r_last_i       (mst_r_last_i),
      .r_valid_o      (slot_r_valid[i]),
      .r_id_o         (slot_r_id[i])
    );
  end

  r_route i_r_route (
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_id_i     (mst_r_id_i),
    .mst_r_data_i   (mst_r_data_i),
    .mst_r_last_i   (mst_r_last_i),
    .mst_r_ready_o  (mst_r_ready_o),
    .slot_r_valid_o (route_r_valid),
    .slot_r_valid_i (slot_r_valid),
    .slot_r_id_i    (slot_r_id),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_ready_i  (slv_r_ready_i),
    .slv_r_id_o     (slv_r_id_o),
    .slv_r_data_o   (slv_r_data_o),
    .slv_r_last_o   (slv_r_last_o)
  );

  spill_register i_spill_register (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (merged_ar_valid),
    .ready_o  (spill_ready),
    .data_i   (merged_ar),
    .valid_o  (mst_ar_valid_o),
    .ready_i  (mst_ar_ready_i),
    .data_o   (mst_ar)
  );

  assign mst_ar_id_o   = mst_ar.id;
  assign mst_ar_addr_o = mst_ar.addr;
  assign mst_ar_len_o  = mst_ar.len;

endmodule

//--- rtl/spill_register.sv
////////////////////
// Two-entry AR cut, order kept
// Ready and valid both come from flops
////////////////////
`timescale 1ns/1ps

module spill_register
  import read_id_serialize_pkg::*;
(
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    valid_i,
  output logic    ready_o,
  input  mst_ar_t data_i,
  output logic    valid_o,
  input  logic    ready_i,
  output mst_ar_t data_o
);

  // Entry A takes new beats, B holds an older one stalled downstream
  mst_ar_t a_data_q;
  mst_ar_t b_data_q;
  logic    a_full_q;
  logic    b_full_q;

  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  // Upstream write into A
  assign a_fill  = valid_i & ready_o;
  // A empties when it moves out, or spills into B
  assign a_drain = a_full_q & ~b_full_q;
  // A spills into B only when downstream stalls
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill || b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  // Falls only with both entries taken
  assign ready_o = ~a_full_q | ~b_full_q;

  assign valid_o = a_full_q | b_full_q;

  // B is older, it goes first
  assign data_o = b_full_q ? b_data_q : a_data_q;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build with Verilator from the project root, run, then search the log
verilator --binary --timing --assert -Wno-fatal -f read_id_serialize.f \
  --top-module tb_read_id_serialize -o tb_read_id_serialize > build.log 2>&1 \
  || { cat build.log; exit 1; }
./obj_dir/tb_read_id_serialize > sim.log 2>&1 ; cat sim.log
grep -q "Simulation finished: PASS" sim.log && exit 0 || exit 1

//--- test/read_id_serialize_checker.sv
////////////////////
// Bound into read_id_serialize
// Covers the AR ports and the R valid after reset
////////////////////
`timescale 1ns/1ps
`include "serialize_defs.svh"

module read_id_serialize_checker
  import read_id_serialize_pkg::*;
(
  input logic    clk_i,
  input logic    arst_n_i,
  input logic    slv_ar_valid_i,
  input logic    slv_ar_ready_o,
  input slv_id_t slv_ar_id_i,
  input addr_t   slv_ar_addr_i,
  input len_t    slv_ar_len_i,
  input logic    mst_ar_valid_o,
  input logic    mst_ar_ready_i,
  input mst_id_t mst_ar_id_o,
  input addr_t   mst_ar_addr_o,
  input len_t    mst_ar_len_o,
  input logic    slv_r_valid_o
);

  // Slave AR holds valid and payload until the handshake
  slv_ar_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (slv_ar_valid_i && !slv_ar_ready_o) |=> (slv_ar_valid_i && $stable(slv_ar_id_i)
      && $stable(slv_ar_addr_i) && $stable(slv_ar_len_i)))
    else $error("slave AR dropped or changed before its handshake");

  // Master AR out of the spill register holds the same way
  mst_ar_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (mst_ar_valid_o && !mst_ar_ready_i) |=> (mst_ar_valid_o && $stable(mst_ar_id_o)
      && $stable(mst_ar_addr_o) && $stable(mst_ar_len_o)))
    else $error("master AR dropped or changed before its handshake");

  // Master ID always names an existing slot
  mst_id_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mst_ar_valid_o |-> (int'(mst_ar_id_o) < `MAX_UNIQ_IDS))
    else $error("master AR ID outside the slot range");

  // No R beat right out of reset
  r_idle_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !slv_r_valid_o)
    else $error("slave R valid high right after reset");

endmodule

bind read_id_serialize read_id_serialize_checker i_read_id_serialize_checker (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .slv_ar_valid_i (slv_ar_valid_i),
  .slv_ar_ready_o (slv_ar_ready_o),
  .slv_ar_id_i    (slv_ar_id_i),
  .slv_ar_addr_i  (slv_ar_addr_i),
  .slv_ar_len_i   (slv_ar_len_i),
  .mst_ar_valid_o (mst_ar_valid_o),
  .mst_ar_ready_i (mst_ar_ready_i),
  .mst_ar_id_o    (mst_ar_id_o),
  .mst_ar_addr_o  (mst_ar_addr_o),
  .mst_ar_len_o   (mst_ar_len_o),
  .slv_r_valid_o  (slv_r_valid_o)
);

//--- test/tb_read_id_serialize.sv
////////////////////
// Directed tests against an in-order-per-ID memory model
// Run ends in failure when the cycle limit is hit
////////////////////
`timescale 1ns/1ps
`include "serialize_defs.svh"

module tb_read_id_serialize
  import read_id_serialize_pkg::*;
();

  localparam int NumSlots    = `MAX_UNIQ_IDS;
  localparam int NumSlvIds   = 1 << `SLV_ID_W;
  localparam int AcceptLimit = 200;
  localparam int DrainLimit  = 2000;
  // 77 reads over all tests with up to 8 beats each and slack for random stalls
  localparam int TotalReads  = 77;
  localparam int MaxCycles   = TotalReads * 8 * 8 + 1000;
  localparam logic [31:0] Seed = 32'h94e8ad44;

  // One read as issued on the slave port
  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } rd_t;

  logic    clk_i;
  logic    arst_n_i;
  logic    slv_ar_valid_i;
  logic    slv_ar_ready_o;
  slv_id_t slv_ar_id_i;
  addr_t   slv_ar_addr_i;
  len_t    slv_ar_len_i;
  logic    slv_r_valid_o;
  logic    slv_r_ready_i;
  slv_id_t slv_r_id_o;
  data_t   slv_r_data_o;
  logic    slv_r_last_o;
  logic    mst_ar_valid_o;
  logic    mst_ar_ready_i;
  mst_id_t mst_ar_id_o;
  addr_t   mst_ar_addr_o;
  len_t    mst_ar_len_o;
  logic    mst_r_valid_i;
  logic    mst_r_ready_o;
  mst_id_t mst_r_id_i;
  data_t   mst_r_data_i;
  logic    mst_r_last_i;

  // Reads between slave accept and master AR
  rd_t     exp_ar_q [$];
  // Per-slot scoreboard in issue order
  rd_t     sb_q [NumSlots][$];
  // Memory model queues indexed by master ID
  rd_t     rsp_q [NumSlots][$];
  int      sb_beat [NumSlots];
  int      rsp_beat [NumSlots];
  slv_id_t done_ids [$];

  int err_cnt;
  int mst_ar_cnt;
  int done_cnt;
  int beat_cnt;
  int cycle_cnt;
  logic [31:0] lfsr_rsp;
  logic [31:0] lfsr_stim;
  logic r_hold;
  logic rand_ready;
  logic r_xfer;
  int   r_cur;
  int   r_start;
  logic r_found;
  rd_t  mon_rd;
  int   mon_slot;

  read_id_serialize i_read_id_serialize (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] lfsr_take(inout logic [31:0] state, input int n);
    logic [31:0] val;
    logic fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = state[31] ^ state[21] ^ state[1] ^ state[0];
      state = {state[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  // Slot from (ID + offset) mod slot count
  function automatic int mapped_slot(input int id);
    return (id + `ID_BASE_OFFSET) % NumSlots;
  endfunction

  function automatic logic all_empty();
    logic empty;
    empty = (exp_ar_q.size() == 0);
    for (int s = 0; s < NumSlots; s++) begin
      empty = empty && (sb_q[s].size() == 0) && (rsp_q[s].size() == 0);
    end
    return empty;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("[ERROR] at %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    err_cnt++;
    $display("[ERROR] at %0t ns %s", $time, msg);
  endtask

  task automatic print_counts();
    $display("Checks done with %0d errors over %0d reads and %0d R beats",
             err_cnt, done_cnt, beat_cnt);
  endtask

  // Monitor and scoreboard sample mid-cycle where all signals are settled
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (slv_ar_valid_i && slv_ar_ready_o) begin
        mon_rd.id   = slv_ar_id_i;
        mon_rd.addr = slv_ar_addr_i;
        mon_rd.len  = slv_ar_len_i;
        exp_ar_q.push_back(mon_rd);
        sb_q[mapped_slot(int'(slv_ar_id_i))].push_back(mon_rd);
      end
      if (mst_ar_valid_o && mst_ar_ready_i) begin
        mst_ar_cnt++;
        assert (exp_ar_q.size() > 0) else note_failure("master AR with no slave AR pending");
        if (exp_ar_q.size() > 0) begin
          mon_rd = exp_ar_q.pop_front();
          mon_slot = mapped_slot(int'(mon_rd.id));
          check_value("mst_ar_id_o", mst_ar_id_o, mon_slot);
          check_value("mst_ar_addr_o", mst_ar_addr_o, mon_rd.addr);
          check_value("mst_ar_len_o", mst_ar_len_o, mon_rd.len);
          rsp_q[mon_slot].push_back(mon_rd);
        end
      end
      // R path is zero-cycle in both directions
      check_value("slv_r_valid_o", slv_r_valid_o, mst_r_valid_i);
      if (mst_r_valid_i) begin
        check_value("mst_r_ready_o", mst_r_ready_o, slv_r_ready_i);
      end
      if (mst_r_valid_i && mst_r_ready_o) begin
        r_xfer = 1'b1;
        if (rsp_beat[r_cur] == int'(rsp_q[r_cur][0].len)) begin
          void'(rsp_q[r_cur].pop_front());
          rsp_beat[r_cur] = 0;
        end else begin
          rsp_beat[r_cur]++;
        end
      end
      if (slv_r_valid_o && slv_r_ready_i) begin
        beat_cnt++;
        mon_slot = int'(mst_r_id_i);
        assert (sb_q[mon_slot].size() > 0) else note_failure("R beat with no read outstanding");
        if (sb_q[mon_slot].size() > 0) begin
          mon_rd = sb_q[mon_slot][0];
          check_value("slv_r_id_o", slv_r_id_o, mon_rd.id);
          check_value("slv_r_data_o", slv_r_data_o,
                      data_t'(mon_rd.addr + addr_t'(sb_beat[mon_slot])));
          check_value("slv_r_last_o", slv_r_last_o, sb_beat[mon_slot] == int'(mon_rd.len));
          if (sb_beat[mon_slot] == int'(mon_rd.len)) begin
            void'(sb_q[mon_slot].pop_front());
            sb_beat[mon_slot] = 0;
            done_ids.push_back(mon_rd.id);
            done_cnt++;
          end else begin
            sb_beat[mon_slot]++;
          end
        end
      end
    end
  end

  // Memory model and ready drivers
  // A beat holds until its handshake, then any master ID with work may go next
  always @(posedge clk_i) begin
    #0.5;
    if (rand_ready) begin
      mst_ar_ready_i = lfsr_take(lfsr_rsp, 1) != 0;
      slv_r_ready_i  = lfsr_take(lfsr_rsp, 1) != 0;
    end else begin
      mst_ar_ready_i = 1'b1;
      slv_r_ready_i  = 1'b1;
    end
    if (!mst_r_valid_i || r_xfer) begin
      mst_r_valid_i = 1'b0;
      mst_r_last_i  = 1'b0;
      if (!r_hold) begin
        r_start = int'(lfsr_take(lfsr_rsp, `MST_ID_W));
        r_found = 1'b0;
        for (int k = 0; k < NumSlots; k++) begin
          if (!r_found && rsp_q[(r_start + k) % NumSlots].size() > 0) begin
            r_found = 1'b1;
            r_cur = (r_start + k) % NumSlots;
          end
        end
        if (r_found) begin
          mst_r_valid_i = 1'b1;
          mst_r_id_i    = mst_id_t'(r_cur);
          mst_r_data_i  = data_t'(rsp_q[r_cur][0].addr) + data_t'(rsp_beat[r_cur]);
          mst_r_last_i  = rsp_beat[r_cur] == int'(rsp_q[r_cur][0].len);
        end
      end
    end
    r_xfer = 1'b0;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MaxCycles) begin
      $display("Timeout after %0d cycles with reads still in flight", cycle_cnt);
      print_counts();
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic drive_ar(input slv_id_t id, input addr_t addr, input len_t len);
    @(posedge clk_i);
    #0.5;
    slv_ar_valid_i = 1'b1;
    slv_ar_id_i    = id;
    slv_ar_addr_i  = addr;
    slv_ar_len_i   = len;
  endtask

  task automatic wait_ar_ready();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!slv_ar_ready_o && n < AcceptLimit) begin
      @(negedge clk_i);
      n++;
    end
    assert (slv_ar_ready_o) else note_failure("slave AR not accepted within the wait limit");
  endtask

  task automatic issue_read(input slv_id_t id, input addr_t addr, input len_t len);
    drive_ar(id, addr, len);
    wait_ar_ready();
  endtask

  task automatic release_ar();
    @(posedge clk_i);
    #0.5;
    slv_ar_valid_i = 1'b0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_ar_len_i   = '0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!all_empty() && n < DrainLimit) begin
      @(negedge clk_i);
      n++;
    end
    assert (all_empty()) else note_failure("reads still outstanding after the drain limit");
  endtask

  task automatic reset_outputs_idle();
    repeat (4) begin
      @(negedge clk_i);
      check_value("mst_ar_valid_o", mst_ar_valid_o, 0);
      check_value("slv_r_valid_o", slv_r_valid_o, 0);
    end
  endtask

  // Master ID and pass-through fields are checked by the monitor
  task automatic slot_mapping();
    for (int i = 0; i < NumSlvIds; i++) begin
      issue_read(slv_id_t'(i), addr_t'(32'h1000_0000 + i * 32'h100), len_t'(i % 4));
    end
    release_ar();
    wait_idle();
  endtask

  task automatic slave_id_restore();
    int beats_exp;
    int beats_base;
    beats_exp = 0;
    beats_base = beat_cnt;
    for (int i = 0; i < 12; i++) begin
      issue_read(slv_id_t'((i * 5) % NumSlvIds), addr_t'(32'h2000_0000 + i * 32'h1000),
                 len_t'(i % 8));
      beats_exp += (i % 8) + 1;
    end
    release_ar();
    wait_idle();
    check_value("R beat count", beat_cnt - beats_base, beats_exp);
  endtask

  // IDs 2 6 10 14 share one slot and must complete in issue order
  task automatic shared_slot_order();
    slv_id_t order [4];
    order = '{4'd2, 4'd6, 4'd10, 4'd14};
    done_ids.delete();
    for (int i = 0; i < 4; i++) begin
      issue_read(order[i], addr_t'(32'h3000_0000 + i * 32'h80), len_t'((i * 3) % 4));
    end
    release_ar();
    wait_idle();
    check_value("completed read count", done_ids.size(), 4);
    for (int i = 0; i < 4 && i < done_ids.size(); i++) begin
      check_value("slv_r_id_o order", done_ids[i], order[i]);
    end
  endtask

  task automatic slot_capacity_limit();
    int ar_base;
    int done_base;
    ar_base = mst_ar_cnt;
    done_base = done_cnt;
    r_hold = 1'b1;
    for (int i = 0; i < `MAX_TXNS_PER_ID; i++) begin
      issue_read(slv_id_t'(3), addr_t'(32'h4000_0000 + i * 32'h40), len_t'(1));
    end
    // Slot now full so this one must wait
    drive_ar(slv_id_t'(3), addr_t'(32'h4000_1000), len_t'(1));
    repeat (8) begin
      @(negedge clk_i);
      check_value("slv_ar_ready_o", slv_ar_ready_o, 0);
    end
    check_value("master AR count", mst_ar_cnt - ar_base, `MAX_TXNS_PER_ID);
    r_hold = 1'b0;
    wait_ar_ready();
    assert (done_cnt > done_base) else note_failure("read accepted into a full slot");
    release_ar();
    wait_idle();
    check_value("master AR count", mst_ar_cnt - ar_base, `MAX_TXNS_PER_ID + 1);
  endtask

  task automatic random_backpressure();
    int done_base;
    slv_id_t id;
    addr_t addr;
    len_t len;
    done_base = done_cnt;
    rand_ready = 1'b1;
    for (int i = 0; i < 40; i++) begin
      id   = slv_id_t'(lfsr_take(lfsr_stim, `SLV_ID_W));
      addr = addr_t'(lfsr_take(lfsr_stim, `ADDR_W));
      len  = len_t'(lfsr_take(lfsr_stim, 2));
      issue_read(id, addr, len);
    end
    release_ar();
    wait_idle();
    rand_ready = 1'b0;
    check_value("completed read count", done_cnt - done_base, 40);
  endtask

  initial begin
    arst_n_i       = 1'b0;
    slv_ar_valid_i = 1'b0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_ar_len_i   = '0;
    slv_r_ready_i  = 1'b1;
    mst_ar_ready_i = 1'b1;
    mst_r_valid_i  = 1'b0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_last_i   = 1'b0;
    sb_beat        = '{default: 0};
    rsp_beat       = '{default: 0};
    err_cnt        = 0;
    mst_ar_cnt     = 0;
    done_cnt       = 0;
    beat_cnt       = 0;
    cycle_cnt      = 0;
    lfsr_rsp       = Seed;
    lfsr_stim      = Seed;
    r_hold         = 1'b0;
    rand_ready     = 1'b0;
    r_xfer         = 1'b0;
    r_cur          = 0;
    repeat (2) @(posedge clk_i);
    #0.5;
    arst_n_i = 1'b1;
    reset_outputs_idle();
    slot_mapping();
    slave_id_restore();
    shared_slot_order();
    slot_capacity_limit();
    random_backpressure();
    print_counts();
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
